// ==== cpu_pipe.f ====
+incdir+common
common/cpu_isa_pkg.sv
common/cpu_pipe_pkg.sv
source/reg_file.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
source/writeback.sv
source/cpu_top.sv
verif/tb_clock_gen.sv
verif/cpu_top_tb.sv

// ==== verif/cpu_top_tb.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top_tb;
    import cpu_isa_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int MEM_WORDS = 1 << (`CPU_IMEM_AW - 2);
    localparam int TIMEOUT = 2000;

    typedef struct packed {
        u32_t pc;
        reg_idx_t rd;
        u32_t data;
    } wr_rec_t;

    typedef struct packed {
        u32_t next_pc;
        logic we;
        reg_idx_t rd;
        u32_t data;
    } step_t;

    logic clk;
    logic rst_n;
    logic icache_req;
    u32_t icache_pa;
    logic icache_busy;
    logic icache_data_valid;
    inst_t icache_data;
    u32_t debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    u32_t debug_wb_rf_wdata;

    inst_t mem [MEM_WORDS];
    u32_t model_regs [`CPU_REG_NUM];
    wr_rec_t expected [$];
    int err_cnt = 0;
    int checked_cnt = 0;
    int expect_total = 0;
    logic timed_out = 1'b0;

    tb_clock_gen clock_gen_i (.clk, .rst_n);

    cpu_top cpu_top_i (
        .clk, .rst_n,
        .icache_req, .icache_pa, .icache_busy,
        .icache_data_valid, .icache_data,
        .debug_wb_pc, .debug_wb_rf_wen,
        .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    function automatic inst_t enc_rrr(logic [16:0] op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic inst_t enc_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] si12);
        return {OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic inst_t enc_branch(logic [5:0] op, logic [15:0] offs, reg_idx_t rj,
                                         reg_idx_t rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic inst_t enc_b(logic [25:0] offs);
        return {OP_B, offs[15:0], offs[25:16]};     // High offset bits sit at the bottom.
    endfunction

    // One architectural step of the ISA subset.
    function automatic step_t ref_step(input u32_t pc, input inst_t inst);
        step_t s;
        u32_t vj;
        u32_t vk;
        u32_t vd;
        u32_t br_off;
        vj = model_regs[inst[9:5]];
        vk = model_regs[inst[14:10]];
        vd = model_regs[inst[4:0]];
        br_off = {{14{inst[25]}}, inst[25:10], 2'b00};
        s.next_pc = pc + 32'd4;
        s.rd = inst[4:0];
        s.we = 1'b1;
        s.data = '0;
        if (inst[31:15] == OP_ADD_W) s.data = vj + vk;
        else if (inst[31:15] == OP_SUB_W) s.data = vj - vk;
        else if (inst[31:15] == OP_AND) s.data = vj & vk;
        else if (inst[31:15] == OP_OR) s.data = vj | vk;
        else if (inst[31:15] == OP_XOR) s.data = vj ^ vk;
        else if (inst[31:22] == OP_ADDI_W) s.data = vj + {{20{inst[21]}}, inst[21:10]};
        else if (inst[31:25] == OP_LU12I_W) s.data = {inst[24:5], 12'h000};
        else begin
            s.we = 1'b0;
            if (inst[31:26] == OP_BEQ && vj == vd) s.next_pc = pc + br_off;
            else if (inst[31:26] == OP_BNE && vj != vd) s.next_pc = pc + br_off;
            else if (inst[31:26] == OP_B)
                s.next_pc = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
        return s;
    endfunction

    task automatic gen_program;
        int kind;
        int offs;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        for (int a = 0; a < MEM_WORDS; a++) mem[a] = inst_t'(a);   // Decodes as a no-op.
        // Registers start undefined in the DUT, so give r1..r7 a value first.
        for (int i = 0; i < 7; i++) mem[i] = enc_addi(reg_idx_t'(i + 1), 5'd0, 12'($urandom));
        for (int i = 7; i < PROG_LEN; i++) begin
            kind = $urandom_range(9, 0);
            rd = reg_idx_t'($urandom_range(7, 0));
            rj = reg_idx_t'($urandom_range(7, 0));
            rk = reg_idx_t'($urandom_range(7, 0));
            offs = $urandom_range(4, 1);
            if (offs > PROG_LEN - i) offs = PROG_LEN - i;
            case (kind)
                0: mem[i] = enc_rrr(OP_ADD_W, rd, rj, rk);
                1: mem[i] = enc_rrr(OP_SUB_W, rd, rj, rk);
                2: mem[i] = enc_rrr(OP_AND, rd, rj, rk);
                3: mem[i] = enc_rrr(OP_OR, rd, rj, rk);
                4: mem[i] = enc_rrr(OP_XOR, rd, rj, rk);
                5: mem[i] = enc_addi(rd, rj, 12'($urandom));
                6: mem[i] = {OP_LU12I_W, 20'($urandom), rd};
                7: mem[i] = enc_branch(OP_BEQ, 16'(offs), rj, rd);
                8: mem[i] = enc_branch(OP_BNE, 16'(offs), rj, rd);
                default: mem[i] = enc_b(26'(offs));
            endcase
        end
        mem[PROG_LEN] = enc_b(26'd0);   // Self-loop ends the program.
    endtask

    task automatic build_expected;
        u32_t pc;
        step_t s;
        int steps;
        logic done;
        for (int r = 0; r < `CPU_REG_NUM; r++) model_regs[r] = '0;
        pc = `CPU_RESET_PC;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4 * PROG_LEN) begin
            s = ref_step(pc, mem[(pc - `CPU_RESET_PC) >> 2]);
            if (s.we && s.rd != '0) begin
                model_regs[s.rd] = s.data;
                expected.push_back('{pc: pc, rd: s.rd, data: s.data});
            end
            done = (s.next_pc == pc);
            pc = s.next_pc;
            steps++;
        end
    endtask

    task automatic wait_reset_release;
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            err_cnt++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic wait_queue_drain;
        int cycles;
        cycles = 0;
        while (expected.size() != 0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            timed_out = 1'b1;
            err_cnt++;
            $display("Timeout: %0d expected writes never retired", expected.size());
        end
    endtask

    // Instruction memory with random latency and busy pulses.
    initial begin : imem_model
        logic pending;
        logic fire;
        int wait_cnt;
        u32_t word;
        inst_t rdata;
        icache_busy = 1'b0;
        icache_data_valid = 1'b0;
        icache_data = '0;
        pending = 1'b0;
        wait_cnt = 0;
        word = '0;
        forever begin
            @(posedge clk);
            fire = 1'b0;
            rdata = '0;
            if (!rst_n) begin
                pending = 1'b0;
            end else begin
                if (icache_req) begin
                    pending = 1'b1;
                    wait_cnt = $urandom_range(3, 0);
                    word = (icache_pa - `CPU_RESET_PC) >> 2;
                end
                if (pending && wait_cnt == 0) begin
                    fire = 1'b1;
                    pending = 1'b0;
                end else if (pending) begin
                    wait_cnt--;
                end
            end
            if (fire && word < MEM_WORDS) begin
                rdata = mem[word];
            end else if (fire) begin
                err_cnt++;
                $display("Instruction fetch outside the program memory, word offset %h", word);
            end
            #1;
            icache_data_valid = fire;
            icache_data = rdata;
            icache_busy = rst_n && ($urandom_range(3, 0) == 0);
        end
    end

    initial begin : wb_checker
        wr_rec_t exp_rec;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && debug_wb_rf_wen !== 4'h0) begin
                if (debug_wb_rf_wen !== 4'hf) begin
                    err_cnt++;
                    $display("Error: debug_wb_rf_wen = %h, expected %h", debug_wb_rf_wen, 4'hf);
                end
                if (expected.size() == 0) begin
                    err_cnt++;
                    $display("Unexpected register write retired at pc %h", debug_wb_pc);
                end else begin
                    exp_rec = expected.pop_front();
                    checked_cnt++;
                    if (debug_wb_pc !== exp_rec.pc) begin
                        err_cnt++;
                        $display("Error: debug_wb_pc = %h, expected %h", debug_wb_pc, exp_rec.pc);
                    end
                    if (debug_wb_rf_wnum !== exp_rec.rd) begin
                        err_cnt++;
                        $display("Error: debug_wb_rf_wnum = %h, expected %h",
                                 debug_wb_rf_wnum, exp_rec.rd);
                    end
                    if (debug_wb_rf_wdata !== exp_rec.data) begin
                        err_cnt++;
                        $display("Error: debug_wb_rf_wdata = %h, expected %h",
                                 debug_wb_rf_wdata, exp_rec.data);
                    end
                end
            end
        end
    end

    initial begin : main_flow
        int unsigned seed;
        seed = 32'hddaefecd;
        void'($urandom(seed));
        gen_program();
        build_expected();
        expect_total = expected.size();
        wait_reset_release();
        if (!timed_out) wait_queue_drain();
        if (!timed_out) repeat (20) @(negedge clk);    // The self-loop must write nothing.
        $display("Writes checked: %0d of %0d, errors: %0d", checked_cnt, expect_total, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;    // Released just after an edge.
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
    input logic clk,
    input logic rst_n,

    output logic icache_req,
    output cpu_isa_pkg::u32_t icache_pa,
    input logic icache_busy,
    input logic icache_data_valid,
    input cpu_isa_pkg::inst_t icache_data,

    output cpu_isa_pkg::u32_t debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output cpu_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_isa_pkg::u32_t debug_wb_rf_wdata
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    fetch_decode_pass_t pass_if;
    decode_execute_pass_t pass_id;
    execute_writeback_pass_t pass_ex;

    wr_pc_req_t ex_wr_pc_req;
    forward_req_t wb_fwd;
    logic flush_front;

    reg_idx_t rj, rk, rd;
    u32_t rj_data, rk_data, rd_data;
    logic reg_we;

    assign flush_front = ex_wr_pc_req.valid;     // Taken branch kills fetch and decode.

    reg_file u_reg_file (
        .clk, .rst_n,
        .rj, .rk,
        .rj_data, .rk_data,
        .we(reg_we),
        .rd,
        .rd_data
    );

    fetch u_fetch (
        .clk, .rst_n,
        .icache_req, .icache_pa, .icache_busy,
        .icache_data_valid, .icache_data,
        .wr_pc_req(ex_wr_pc_req),
        .flush(flush_front),
        .pass_out(pass_if)
    );

    decode u_decode (
        .clk, .rst_n,
        .flush(flush_front),
        .pass_in(pass_if),
        .rj, .rk,
        .rj_data, .rk_data,
        .pass_out(pass_id)
    );

    execute u_execute (
        .clk, .rst_n,
        .pass_in(pass_id),
        .fwd(wb_fwd),
        .wr_pc_req(ex_wr_pc_req),
        .pass_out(pass_ex)
    );

    writeback u_writeback (
        .clk, .rst_n,
        .pass_in(pass_ex),
        .reg_we,
        .reg_idx(rd),
        .reg_data(rd_data),
        .fwd(wb_fwd),
        .debug_wb_pc, .debug_wb_rf_wdata,
        .debug_wb_rf_wen, .debug_wb_rf_wnum
    );

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ns

module writeback (
    input logic clk,
    input logic rst_n,
    input cpu_pipe_pkg::execute_writeback_pass_t pass_in,
    output logic reg_we,
    output cpu_isa_pkg::reg_idx_t reg_idx,
    output cpu_isa_pkg::u32_t reg_data,
    output cpu_pipe_pkg::forward_req_t fwd,
    output cpu_isa_pkg::u32_t debug_wb_pc,
    output cpu_isa_pkg::u32_t debug_wb_rf_wdata,
    output logic [3:0] debug_wb_rf_wen,
    output cpu_isa_pkg::reg_idx_t debug_wb_rf_wnum
);
    logic wen;

    assign wen = pass_in.valid && pass_in.we && (pass_in.rd != '0);   // r0 stays zero.

    assign reg_we = wen;
    assign reg_idx = pass_in.rd;
    assign reg_data = pass_in.result;

    assign fwd.valid = wen;
    assign fwd.rd = pass_in.rd;
    assign fwd.data = pass_in.result;

    assign debug_wb_pc = pass_in.pc;
    assign debug_wb_rf_wen = {4{wen}};
    assign debug_wb_rf_wnum = pass_in.rd;
    assign debug_wb_rf_wdata = pass_in.result;

    a_wen_idx: assert property (@(posedge clk) disable iff (!rst_n)
        (debug_wb_rf_wen != 4'h0) |-> (debug_wb_rf_wnum != '0 && !$isunknown(debug_wb_rf_wdata)));

endmodule

// ==== execute/execute.sv ====
`timescale 1ns/1ns

module execute (
    input logic clk,
    input logic rst_n,
    input cpu_pipe_pkg::decode_execute_pass_t pass_in,
    input cpu_pipe_pkg::forward_req_t fwd,
    output cpu_pipe_pkg::wr_pc_req_t wr_pc_req,
    output cpu_pipe_pkg::execute_writeback_pass_t pass_out
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    u32_t src_a;
    u32_t src_b;
    u32_t opnd_b;
    u32_t result;
    logic taken;
    execute_writeback_pass_t ex;

    // Writeback holds the previous instruction's result.
    assign src_a = (fwd.valid && fwd.rd == pass_in.rj) ? fwd.data : pass_in.rj_data;
    assign src_b = (fwd.valid && fwd.rd == pass_in.rk) ? fwd.data : pass_in.rk_data;
    assign opnd_b = pass_in.use_imm ? pass_in.imm : src_b;

    always_comb begin
        case (pass_in.alu_op)
            ALU_ADD: result = src_a + opnd_b;
            ALU_SUB: result = src_a - opnd_b;
            ALU_AND: result = src_a & opnd_b;
            ALU_OR: result = src_a | opnd_b;
            ALU_XOR: result = src_a ^ opnd_b;
            default: result = opnd_b;
        endcase
    end

    always_comb begin
        case (pass_in.br_kind)
            BR_EQ: taken = (src_a == src_b);
            BR_NE: taken = (src_a != src_b);
            BR_ALWAYS: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign wr_pc_req.valid = pass_in.valid && taken;
    assign wr_pc_req.pc = pass_in.br_target;

    assign ex.valid = pass_in.valid;
    assign ex.pc = pass_in.pc;
    assign ex.rd = pass_in.rd;
    assign ex.we = pass_in.we;
    assign ex.result = result;

    always_ff @(posedge clk) begin
        pass_out <= ex;
        if (!rst_n) pass_out.valid <= 1'b0;
    end

    // The flush empties decode, so a redirect is followed by a bubble.
    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        wr_pc_req.valid |-> pass_in.valid ##1 !wr_pc_req.valid);

endmodule

// ==== decode/decode.sv ====
`timescale 1ns/1ns

module decode (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input cpu_pipe_pkg::fetch_decode_pass_t pass_in,
    output cpu_isa_pkg::reg_idx_t rj,
    output cpu_isa_pkg::reg_idx_t rk,
    input cpu_isa_pkg::u32_t rj_data,
    input cpu_isa_pkg::u32_t rk_data,
    output cpu_pipe_pkg::decode_execute_pass_t pass_out
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    inst_t inst;
    logic is_rrr;
    alu_op_t rrr_op;
    decode_execute_pass_t dec;

    assign inst = pass_in.inst;
    assign rj = inst[9:5];
    // beq and bne compare rj against the rd field.
    assign rk = (inst[31:26] == OP_BEQ || inst[31:26] == OP_BNE) ? inst[4:0] : inst[14:10];

    always_comb begin
        is_rrr = 1'b1;
        rrr_op = ALU_ADD;
        case (inst[31:15])
            OP_ADD_W: rrr_op = ALU_ADD;
            OP_SUB_W: rrr_op = ALU_SUB;
            OP_AND: rrr_op = ALU_AND;
            OP_OR: rrr_op = ALU_OR;
            OP_XOR: rrr_op = ALU_XOR;
            default: is_rrr = 1'b0;
        endcase
    end

    always_comb begin
        dec = '0;
        dec.valid = pass_in.valid && !flush;
        dec.pc = pass_in.pc;
        dec.alu_op = ALU_ADD;
        dec.rj = rj;
        dec.rj_data = rj_data;
        dec.rk = rk;
        dec.rk_data = rk_data;
        dec.rd = inst[4:0];
        dec.br_kind = BR_NONE;
        if (is_rrr) begin
            dec.alu_op = rrr_op;
            dec.we = 1'b1;
        end else if (inst[31:22] == OP_ADDI_W) begin
            dec.imm = {{20{inst[21]}}, inst[21:10]};
            dec.use_imm = 1'b1;
            dec.we = 1'b1;
        end else if (inst[31:25] == OP_LU12I_W) begin
            dec.alu_op = ALU_IMM;
            dec.imm = {inst[24:5], 12'h000};
            dec.use_imm = 1'b1;
            dec.we = 1'b1;
        end else if (inst[31:26] == OP_BEQ || inst[31:26] == OP_BNE) begin
            dec.br_kind = (inst[26]) ? BR_NE : BR_EQ;
            dec.br_target = pass_in.pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == OP_B) begin
            dec.br_kind = BR_ALWAYS;
            dec.br_target = pass_in.pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        pass_out <= dec;
        if (!rst_n) pass_out.valid <= 1'b0;
    end

endmodule

// ==== fetch/fetch.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch (
    input logic clk,
    input logic rst_n,
    output logic icache_req,
    output cpu_isa_pkg::u32_t icache_pa,
    input logic icache_busy,
    input logic icache_data_valid,
    input cpu_isa_pkg::inst_t icache_data,
    input cpu_pipe_pkg::wr_pc_req_t wr_pc_req,
    input logic flush,
    output cpu_pipe_pkg::fetch_decode_pass_t pass_out
);
    import cpu_isa_pkg::*;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_t;

    fetch_state_t state;
    u32_t pc;
    logic discard;      // Response in flight belongs to a flushed path.
    logic req_en;
    logic accept;

    assign icache_pa = pc;
    assign icache_req = (state == FETCH_IDLE) && req_en && !icache_busy && !flush;
    assign accept = (state == FETCH_WAIT) && icache_data_valid && !discard;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
            pc <= `CPU_RESET_PC;
            discard <= 1'b0;
            req_en <= 1'b0;
        end else begin
            req_en <= 1'b1;     // First request one cycle after reset.
            if (wr_pc_req.valid) begin
                pc <= wr_pc_req.pc;
            end else if (accept) begin
                pc <= pc + 32'd4;
            end
            case (state)
                FETCH_IDLE: if (icache_req) state <= FETCH_WAIT;
                FETCH_WAIT: if (icache_data_valid) state <= FETCH_IDLE;
                default: state <= FETCH_IDLE;
            endcase
            if (icache_data_valid) begin
                discard <= 1'b0;
            end else if (flush && state == FETCH_WAIT) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pass_out.valid <= accept && !flush;
        pass_out.pc <= pc;
        pass_out.inst <= icache_data;
        if (!rst_n) pass_out.valid <= 1'b0;
    end

    a_req_legal: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req |-> (!icache_busy && icache_pa[1:0] == 2'b00
            && (icache_pa - `CPU_RESET_PC) < (32'd1 << `CPU_IMEM_AW)));

    // One request in flight; the next may only follow its response.
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req |=> (!icache_req until_with icache_data_valid));

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module reg_file (
    input logic clk,
    input logic rst_n,
    input cpu_isa_pkg::reg_idx_t rj,
    input cpu_isa_pkg::reg_idx_t rk,
    output cpu_isa_pkg::u32_t rj_data,
    output cpu_isa_pkg::u32_t rk_data,
    input logic we,
    input cpu_isa_pkg::reg_idx_t rd,
    input cpu_isa_pkg::u32_t rd_data
);
    import cpu_isa_pkg::*;

    u32_t regs [`CPU_REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs[0] <= '0;      // Entry 0 is r0 and is never written.
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // New data wins over the array when the same register is written.
    assign rj_data = (we && rd != '0 && rd == rj) ? rd_data : regs[rj];
    assign rk_data = (we && rd != '0 && rd == rk) ? rd_data : regs[rk];

    // r0 reads zero on both ports.
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rj != '0 || rj_data == '0) && (rk != '0 || rk_data == '0));

endmodule

// ==== common/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_ALWAYS
    } br_kind_t;

    typedef struct packed {
        logic valid;
        cpu_isa_pkg::u32_t pc;
        cpu_isa_pkg::inst_t inst;
    } fetch_decode_pass_t;

    typedef struct packed {
        logic valid;
        cpu_isa_pkg::u32_t pc;
        cpu_isa_pkg::alu_op_t alu_op;
        cpu_isa_pkg::reg_idx_t rj;
        cpu_isa_pkg::u32_t rj_data;
        cpu_isa_pkg::reg_idx_t rk;
        cpu_isa_pkg::u32_t rk_data;
        cpu_isa_pkg::u32_t imm;
        logic use_imm;              // Immediate replaces the rk operand.
        cpu_isa_pkg::reg_idx_t rd;
        logic we;
        br_kind_t br_kind;
        cpu_isa_pkg::u32_t br_target;
    } decode_execute_pass_t;

    typedef struct packed {
        logic valid;
        cpu_isa_pkg::u32_t pc;
        cpu_isa_pkg::reg_idx_t rd;
        logic we;
        cpu_isa_pkg::u32_t result;
    } execute_writeback_pass_t;

    typedef struct packed {
        logic valid;
        cpu_isa_pkg::u32_t pc;
    } wr_pc_req_t;

    typedef struct packed {
        logic valid;
        cpu_isa_pkg::reg_idx_t rd;
        cpu_isa_pkg::u32_t data;
    } forward_req_t;

endpackage

// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] inst_t;

    // Three-register ops, matched on inst[31:15].
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND = 17'h00029;
    localparam logic [16:0] OP_OR = 17'h0002a;
    localparam logic [16:0] OP_XOR = 17'h0002b;

    localparam logic [9:0] OP_ADDI_W = 10'h00a;   // inst[31:22].
    localparam logic [6:0] OP_LU12I_W = 7'h0a;    // inst[31:25].

    // Branches, matched on inst[31:26].
    localparam logic [5:0] OP_B = 6'h14;
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_IMM     // Result is the immediate itself.
    } alu_op_t;

endpackage

// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// First instruction fetched once reset is released.
`define CPU_RESET_PC 32'h1c000000

// Architectural integer registers.
`define CPU_REG_NUM 32

// Byte-address width of the instruction memory behind the fetch port.
`define CPU_IMEM_AW 12

`endif
